//--- src/corr_settings.svh
// correlator settings: tap count and datapath widths for the code correlator
`ifndef CORR_SETTINGS_SVH
`define CORR_SETTINGS_SVH

// ----------------------------------------
// correlator geometry
`define CORR_NUM_TAPS   8   // taps, half a chip apart

// ----------------------------------------
// datapath widths
`define CORR_ACC_W      16  // accumulator and dump sums
`define CORR_NCO_W      32  // carrier and code phase accumulators
`define CORR_IQ_W       5   // signed sample after mixing
`define CORR_DUMP_LEN_W 16  // dump length in chips

// ----------------------------------------
// bus
`define CORR_WB_AW      3   // wishbone word address

`endif

//--- src/corr_pkg.sv
// correlator package: sample, configuration, bus and dump types shared by all blocks
`default_nettype none
`include "corr_settings.svh"

package corr_pkg;

	// ----------------------------------------
	// samples
	typedef struct packed {
		logic       i_sign;  // I nibble, sign/magnitude
		logic [2:0] i_mag;
		logic       q_sign;  // Q nibble, sign/magnitude
		logic [2:0] q_mag;
	} raw_sample_t;

	typedef struct packed {
		logic                         valid;
		logic signed [`CORR_IQ_W-1:0] i;  // two's complement after rotation
		logic signed [`CORR_IQ_W-1:0] q;
	} iq_sample_t;

	// ----------------------------------------
	// configuration seen by the datapath
	typedef struct packed {
		logic [`CORR_NCO_W-1:0]      carrier_freq;
		logic [`CORR_NCO_W-1:0]      code_freq;
		logic [31:0]                 prn_poly;  // lfsr taps
		logic [31:0]                 prn_seed;  // lfsr state on restart
		logic [`CORR_DUMP_LEN_W-1:0] dump_len;  // chips per coherent dump
		logic [1:0]                  post_shift;
	} corr_cfg_t;

	// ----------------------------------------
	// wishbone classic
	typedef struct packed {
		logic                   cyc;
		logic                   stb;
		logic                   we;
		logic [`CORR_WB_AW-1:0] adr;  // word address
		logic [31:0]            dat_w;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat_r;
	} wb_rsp_t;

	// ----------------------------------------
	// serial dump, one correlator per beat
	typedef struct packed {
		logic                   valid;
		logic [2:0]             idx;
		logic [`CORR_ACC_W-1:0] i_sum;
		logic [`CORR_ACC_W-1:0] q_sum;
	} dump_out_t;

	typedef enum logic [`CORR_WB_AW-1:0] {
		CTRL          = 3'd0,  // bit 0 run, writing 1 restarts
		CARRIER_FREQ  = 3'd1,
		CARRIER_PHASE = 3'd2,  // read gives live phase
		CODE_FREQ     = 3'd3,
		PRN_POLY      = 3'd4,
		PRN_SEED      = 3'd5,
		DUMP_CFG      = 3'd6,  // len 15:0, post-shift 17:16
		STATUS        = 3'd7   // read only, bit 0 overrun
	} wb_reg_e;

	typedef enum logic {
		IDLE,
		UNLOAD
	} unload_state_e;

endpackage

`default_nettype wire

//--- src/corr_regs.sv
// correlator registers: wishbone classic slave holding configuration and status
`timescale 1ns/1ps
`default_nettype none
`include "corr_settings.svh"

module corr_regs (
	input  wire                      clk,
	input  wire                      rst_b,
	input  wire corr_pkg::wb_req_t   wb_i,
	input  wire  [`CORR_NCO_W-1:0]   phase_i,       // live carrier phase
	input  wire                      overrun_i,
	output corr_pkg::wb_rsp_t        wb_o,
	output corr_pkg::corr_cfg_t      cfg_o,
	output logic                     restart_o,     // one cycle
	output logic                     phase_load_o,  // one cycle
	output logic [`CORR_NCO_W-1:0]   phase_val_o
);

	logic              req;      // new transfer, ack not yet given
	logic              run_q;
	corr_pkg::wb_reg_e addr;
	logic [31:0]       rd_data;

	assign req  = wb_i.cyc && wb_i.stb && !wb_o.ack;
	assign addr = corr_pkg::wb_reg_e'(wb_i.adr);

	// ----------------------------------------
	// read mux
	always_comb
	begin
		case (addr)
			corr_pkg::CTRL:          rd_data = {31'd0, run_q};
			corr_pkg::CARRIER_FREQ:  rd_data = cfg_o.carrier_freq;
			corr_pkg::CARRIER_PHASE: rd_data = phase_i;
			corr_pkg::CODE_FREQ:     rd_data = cfg_o.code_freq;
			corr_pkg::PRN_POLY:      rd_data = cfg_o.prn_poly;
			corr_pkg::PRN_SEED:      rd_data = cfg_o.prn_seed;
			corr_pkg::DUMP_CFG:      rd_data = {14'd0, cfg_o.post_shift, cfg_o.dump_len};
			corr_pkg::STATUS:        rd_data = {31'd0, overrun_i};
			default:                 rd_data = '0;
		endcase
	end

	// ----------------------------------------
	// ack, write decode and pulses
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
		begin
			wb_o         <= '0;
			cfg_o        <= '0;
			run_q        <= 1'b0;
			restart_o    <= 1'b0;
			phase_load_o <= 1'b0;
		end
		else
		begin
			wb_o.ack     <= req;  // single cycle, next after request
			restart_o    <= 1'b0;
			phase_load_o <= 1'b0;
			if (req && !wb_i.we)
				wb_o.dat_r <= rd_data;  // lines up with ack
			if (req && wb_i.we)
			begin
				case (addr)
					corr_pkg::CTRL:
					begin
						run_q     <= wb_i.dat_w[0];
						restart_o <= wb_i.dat_w[0];  // run=1 restarts channel
					end
					corr_pkg::CARRIER_FREQ:  cfg_o.carrier_freq <= wb_i.dat_w;
					corr_pkg::CARRIER_PHASE: phase_load_o       <= 1'b1;
					corr_pkg::CODE_FREQ:     cfg_o.code_freq    <= wb_i.dat_w;
					corr_pkg::PRN_POLY:      cfg_o.prn_poly     <= wb_i.dat_w;
					corr_pkg::PRN_SEED:      cfg_o.prn_seed     <= wb_i.dat_w;
					corr_pkg::DUMP_CFG:
					begin
						cfg_o.dump_len   <= wb_i.dat_w[15:0];
						cfg_o.post_shift <= wb_i.dat_w[17:16];
					end
					default: ;  // status is read only
				endcase
			end
		end
	end

	// load value for the carrier nco
	always_ff @(posedge clk)
		if (req && wb_i.we && addr == corr_pkg::CARRIER_PHASE)
			phase_val_o <= wb_i.dat_w;

	// every ack answers a request seen one cycle earlier
	assert property (@(posedge clk) disable iff (!rst_b)
		wb_o.ack |-> $past(wb_i.cyc && wb_i.stb))
		else $error("ack without a request");

endmodule

`default_nettype wire

//--- src/carrier_mixer.sv
// carrier mixer: nco phase accumulator and quadrant rotation of sign/magnitude samples
`timescale 1ns/1ps
`default_nettype none
`include "corr_settings.svh"

module carrier_mixer (
	input  wire                         clk,
	input  wire                         rst_b,
	input  wire                         sample_en_i,
	input  wire corr_pkg::raw_sample_t  sample_i,
	input  wire  [`CORR_NCO_W-1:0]      carrier_freq_i,
	input  wire                         phase_load_i,
	input  wire  [`CORR_NCO_W-1:0]      phase_val_i,
	output logic [`CORR_NCO_W-1:0]      phase_o,
	output corr_pkg::iq_sample_t        iq_o
);

	logic [1:0]                   quad;    // top two phase bits
	logic signed [`CORR_IQ_W-1:0] i_tc;
	logic signed [`CORR_IQ_W-1:0] q_tc;
	logic signed [`CORR_IQ_W-1:0] i_swap;
	logic signed [`CORR_IQ_W-1:0] q_swap;
	logic signed [`CORR_IQ_W-1:0] i_rot;
	logic signed [`CORR_IQ_W-1:0] q_rot;

	function automatic logic signed [`CORR_IQ_W-1:0] sm_to_tc(
		input logic       sign,
		input logic [2:0] mag
	);
		logic signed [`CORR_IQ_W-1:0] val;
		val = `CORR_IQ_W'(mag);  // zero extend magnitude
		return sign ? -val : val;
	endfunction

	assign i_tc = sm_to_tc(sample_i.i_sign, sample_i.i_mag);
	assign q_tc = sm_to_tc(sample_i.q_sign, sample_i.q_mag);

	// ----------------------------------------
	// rotation by quadrant
	// 0:(I,Q) 1:(Q,-I) 2:(-I,-Q) 3:(-Q,I)
	assign quad   = phase_o[`CORR_NCO_W-1 -: 2];
	assign i_swap = quad[0] ? q_tc : i_tc;                  // odd quadrants swap
	assign q_swap = quad[0] ? i_tc : q_tc;
	assign i_rot  = quad[1] ? -i_swap : i_swap;
	assign q_rot  = (quad[1] ^ quad[0]) ? -q_swap : q_swap;

	// ----------------------------------------
	// output register and carrier nco
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
		begin
			phase_o <= '0;
			iq_o    <= '0;
		end
		else
		begin
			iq_o.valid <= sample_en_i;
			if (sample_en_i)
			begin
				iq_o.i <= i_rot;
				iq_o.q <= q_rot;
			end
			if (phase_load_i)
				phase_o <= phase_val_i;                       // load wins over step
			else if (sample_en_i)
				phase_o <= phase_o + carrier_freq_i;          // step after use
		end
	end

	// one cycle from sample to mixed sample
	assert property (@(posedge clk) disable iff (!rst_b)
		iq_o.valid == $past(sample_en_i))
		else $error("mixed valid out of step with sample enable");

endmodule

`default_nettype wire

//--- src/code_prn_gen.sv
// code generator: code nco, half-chip sub-phase, fibonacci lfsr prn and tap shift register
`timescale 1ns/1ps
`default_nettype none
`include "corr_settings.svh"

module code_prn_gen (
	input  wire                        clk,
	input  wire                        rst_b,
	input  wire corr_pkg::iq_sample_t  iq_i,
	input  wire                        restart_i,
	input  wire  [`CORR_NCO_W-1:0]     code_freq_i,
	input  wire  [31:0]                poly_i,
	input  wire  [31:0]                seed_i,
	output logic [`CORR_NUM_TAPS-1:0]  taps_o,       // bit 0 earliest
	output logic                       chip_tick_o
);

	logic [`CORR_NCO_W-1:0] code_phase;
	logic [`CORR_NCO_W:0]   phase_sum;  // carry on top
	logic                   half_chip;
	logic                   sub_phase;  // second half of chip
	logic [31:0]            lfsr;
	logic                   feedback;

	// ----------------------------------------
	// code nco
	assign phase_sum   = {1'b0, code_phase} + {1'b0, code_freq_i};
	assign half_chip   = iq_i.valid && phase_sum[`CORR_NCO_W];
	assign chip_tick_o = half_chip && sub_phase;   // every second half-chip
	assign feedback    = ^(lfsr & poly_i);         // parity of masked state

	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
		begin
			code_phase <= '0;
			sub_phase  <= 1'b0;
			lfsr       <= '0;
			taps_o     <= '0;
		end
		else if (restart_i)
		begin
			code_phase <= '0;
			sub_phase  <= 1'b0;
			lfsr       <= seed_i;
			taps_o     <= '0;
		end
		else
		begin
			if (iq_i.valid)
				code_phase <= phase_sum[`CORR_NCO_W-1:0];
			if (half_chip)
			begin
				sub_phase <= !sub_phase;
				// current chip into tap 0, taps half a chip apart
				taps_o    <= {taps_o[`CORR_NUM_TAPS-2:0], lfsr[0]};
			end
			if (chip_tick_o)
				lfsr <= {feedback, lfsr[31:1]};  // enters at top, chip is bit 0
		end
	end

	// chip boundaries only come with a mixed sample
	assert property (@(posedge clk) disable iff (!rst_b)
		chip_tick_o |-> iq_i.valid)
		else $error("chip tick without a sample");

endmodule

`default_nettype wire

//--- src/corr_bank.sv
// correlator bank: eight i/q accumulators, coherent dump capture and serial unload
`timescale 1ns/1ps
`default_nettype none
`include "corr_settings.svh"

module corr_bank (
	input  wire                          clk,
	input  wire                          rst_b,
	input  wire corr_pkg::iq_sample_t    iq_i,
	input  wire  [`CORR_NUM_TAPS-1:0]    taps_i,
	input  wire                          chip_tick_i,
	input  wire                          restart_i,
	input  wire  [`CORR_DUMP_LEN_W-1:0]  dump_len_i,
	input  wire  [1:0]                   post_shift_i,
	output corr_pkg::dump_out_t          dump_o,
	output logic                         overrun_o   // sticky until restart
);

	logic [`CORR_DUMP_LEN_W-1:0]   chip_cnt;
	logic [`CORR_DUMP_LEN_W-1:0]   chip_cnt_nxt;
	logic                          capture;    // last chip of dump period
	logic signed [`CORR_ACC_W-1:0] i_ext;
	logic signed [`CORR_ACC_W-1:0] q_ext;
	logic signed [`CORR_ACC_W-1:0] cap_i [`CORR_NUM_TAPS];
	logic signed [`CORR_ACC_W-1:0] cap_q [`CORR_NUM_TAPS];
	corr_pkg::unload_state_e       state;
	logic [2:0]                    idx;

	assign i_ext        = $signed(iq_i.i);  // sign extend
	assign q_ext        = $signed(iq_i.q);
	assign chip_cnt_nxt = chip_cnt + 1'b1;
	assign capture      = chip_tick_i && !restart_i && (chip_cnt_nxt == dump_len_i);

	// ----------------------------------------
	// accumulators, one pair per tap
	genvar k;
	generate
		for (k = 0; k < `CORR_NUM_TAPS; k++)
		begin : g_tap
			logic signed [`CORR_ACC_W-1:0] acc_i;
			logic signed [`CORR_ACC_W-1:0] acc_q;
			logic signed [`CORR_ACC_W-1:0] sum_i;
			logic signed [`CORR_ACC_W-1:0] sum_q;

			// chip 1 is -1
			assign sum_i = taps_i[k] ? acc_i - i_ext : acc_i + i_ext;
			assign sum_q = taps_i[k] ? acc_q - q_ext : acc_q + q_ext;

			always_ff @(posedge clk or negedge rst_b)
			begin
				if (!rst_b)
				begin
					acc_i <= '0;
					acc_q <= '0;
				end
				else if (restart_i || capture)
				begin
					acc_i <= '0;  // new period starts empty
					acc_q <= '0;
				end
				else if (iq_i.valid)
				begin
					acc_i <= sum_i;
					acc_q <= sum_q;
				end
			end

			// captured sum holds the closing sample
			always_ff @(posedge clk)
				if (capture)
				begin
					cap_i[k] <= sum_i;
					cap_q[k] <= sum_q;
				end
		end
	endgenerate

	// ----------------------------------------
	// chip count, unload fsm, overrun
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
		begin
			chip_cnt  <= '0;
			state     <= corr_pkg::IDLE;
			idx       <= '0;
			overrun_o <= 1'b0;
		end
		else
		begin
			if (restart_i || capture)
				chip_cnt <= '0;
			else if (chip_tick_i)
				chip_cnt <= chip_cnt_nxt;

			if (restart_i)
				overrun_o <= 1'b0;
			else if (capture && state == corr_pkg::UNLOAD)
				overrun_o <= 1'b1;          // new dump before old one left

			if (capture)
			begin
				state <= corr_pkg::UNLOAD;  // start or restart unload
				idx   <= '0;
			end
			else if (state == corr_pkg::UNLOAD)
			begin
				idx <= idx + 3'd1;
				if (idx == 3'd7)
					state <= corr_pkg::IDLE;
			end
		end
	end

	assign dump_o.valid = (state == corr_pkg::UNLOAD);
	assign dump_o.idx   = idx;
	assign dump_o.i_sum = cap_i[idx] >>> post_shift_i;  // arithmetic post-shift
	assign dump_o.q_sum = cap_q[idx] >>> post_shift_i;

	// clean dump is eight beats then a gap
	assert property (@(posedge clk) disable iff (!rst_b || overrun_o)
		$rose(dump_o.valid) |-> dump_o.valid[*8] ##1 !dump_o.valid)
		else $error("dump burst length not 8");

	assert property (@(posedge clk) disable iff (!rst_b || overrun_o)
		dump_o.valid && $past(dump_o.valid) |-> dump_o.idx == 3'($past(dump_o.idx) + 3'd1))
		else $error("dump index skipped");

endmodule

`default_nettype wire

//--- src/correlator_top.sv
// correlator top: single channel with register file, mixer, code generator and tap bank
`timescale 1ns/1ps
`default_nettype none
`include "corr_settings.svh"

module correlator_top (
	input  wire                        clk,
	input  wire                        rst_b,
	input  wire corr_pkg::wb_req_t     wb_i,
	output corr_pkg::wb_rsp_t          wb_o,
	input  wire                        sample_en_i,
	input  wire corr_pkg::raw_sample_t sample_i,
	output corr_pkg::dump_out_t        dump_o
);

	corr_pkg::corr_cfg_t       cfg;
	corr_pkg::iq_sample_t      iq;          // mixed samples
	logic                      restart;
	logic                      phase_load;
	logic [`CORR_NCO_W-1:0]    phase_val;
	logic [`CORR_NCO_W-1:0]    phase;       // live carrier phase
	logic [`CORR_NUM_TAPS-1:0] taps;
	logic                      chip_tick;
	logic                      overrun;

	// ----------------------------------------
	// control
	corr_regs u_regs (
		.clk          (clk),
		.rst_b        (rst_b),
		.wb_i         (wb_i),
		.phase_i      (phase),
		.overrun_i    (overrun),
		.wb_o         (wb_o),
		.cfg_o        (cfg),
		.restart_o    (restart),
		.phase_load_o (phase_load),
		.phase_val_o  (phase_val)
	);

	// ----------------------------------------
	// datapath
	carrier_mixer u_mixer (
		.clk            (clk),
		.rst_b          (rst_b),
		.sample_en_i    (sample_en_i),
		.sample_i       (sample_i),
		.carrier_freq_i (cfg.carrier_freq),
		.phase_load_i   (phase_load),
		.phase_val_i    (phase_val),
		.phase_o        (phase),
		.iq_o           (iq)
	);

	code_prn_gen u_code (
		.clk         (clk),
		.rst_b       (rst_b),
		.iq_i        (iq),
		.restart_i   (restart),
		.code_freq_i (cfg.code_freq),
		.poly_i      (cfg.prn_poly),
		.seed_i      (cfg.prn_seed),
		.taps_o      (taps),
		.chip_tick_o (chip_tick)
	);

	corr_bank u_bank (
		.clk          (clk),
		.rst_b        (rst_b),
		.iq_i         (iq),
		.taps_i       (taps),
		.chip_tick_i  (chip_tick),
		.restart_i    (restart),
		.dump_len_i   (cfg.dump_len),
		.post_shift_i (cfg.post_shift),
		.dump_o       (dump_o),
		.overrun_o    (overrun)
	);

endmodule

`default_nettype wire

//--- testbench/tb_model.svh
// correlator reference model: expected dump sums, xorshift source and result bookkeeping
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int          err_cnt  = 0;
int          err_mark = 0;   // errors before current test
int          pass_cnt = 0;
int          fail_cnt = 0;
logic [31:0] rng      = 32'd32;  // xorshift state

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// sign/magnitude nibble as a plain integer
function automatic int sm_value(input logic s, input logic [2:0] m);
	int v;
	v = int'(m);
	return s ? -v : v;
endfunction

// quadrant rule 0:(I,Q) 1:(Q,-I) 2:(-I,-Q) 3:(-Q,I)
function automatic int rotated(input int i, input int q, input logic [1:0] quad, input bit want_q);
	case (quad)
		2'd0:    return want_q ? q : i;
		2'd1:    return want_q ? -i : q;
		2'd2:    return want_q ? -q : -i;
		default: return want_q ? i : -q;
	endcase
endfunction

// every chip +1, eight samples per chip
function automatic logic [`CORR_ACC_W-1:0] expected_sum(input int comp, input int len, input int shift);
	int total;
	total = comp * 8 * len;
	return `CORR_ACC_W'(total >>> shift);  // arithmetic post-shift
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (exp === act)
	else
	begin
		$display("error %0t %s expected %0h got %0h", $time, name, exp, act);
		err_cnt++;
	end
endtask

task automatic open_test();
	err_mark = err_cnt;
endtask

task automatic close_test(input string name);
	if (err_cnt == err_mark)
		pass_cnt++;
	else
		fail_cnt++;
	$display("%s: %s", name, (err_cnt == err_mark) ? "ok" : "FAILED");
endtask

`endif

//--- testbench/tb_correlator.sv
// correlator testbench drives wishbone setup and constant samples and checks the dumps
`timescale 1ns/1ps
`default_nettype none
`include "corr_settings.svh"

module tb_correlator;

	logic                  clk = 1'b0;
	logic                  rst_b;
	corr_pkg::wb_req_t     wb_req;
	corr_pkg::wb_rsp_t     wb_rsp;
	logic                  sample_en;
	corr_pkg::raw_sample_t raw_sample;
	corr_pkg::dump_out_t   dump;
	int                    cycle_cnt = 0;
	bit                    framing_on;          // off while overrun is forced
	bit                    timed_out = 1'b0;
	string                 hang_what;

	`include "tb_model.svh"

	correlator_top dut_i (
		.clk         (clk),
		.rst_b       (rst_b),
		.wb_i        (wb_req),
		.wb_o        (wb_rsp),
		.sample_en_i (sample_en),
		.sample_i    (raw_sample),
		.dump_o      (dump)
	);

	always #2 clk = ~clk;                       // 4 ns period

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// ----------------------------------------
	// bus and framing checks
	assert property (@(posedge clk) disable iff (!rst_b) wb_rsp.ack |=> !wb_rsp.ack)
	else
	begin
		$display("error %0t wb_o.ack stayed high for more than one cycle", $time);
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (!rst_b || !framing_on)
		$rose(dump.valid) |-> dump.idx == 3'd0)
	else
	begin
		$display("error %0t dump burst did not start at index 0", $time);
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (!rst_b || !framing_on)
		dump.valid && dump.idx != 3'd7
		|=> dump.valid && dump.idx == 3'($past(dump.idx) + 3'd1))
	else
	begin
		$display("error %0t dump burst broke off or skipped an index", $time);
		err_cnt++;
	end

	assert property (@(posedge clk) disable iff (!rst_b || !framing_on)
		dump.valid && dump.idx == 3'd7 |=> !dump.valid)
	else
	begin
		$display("error %0t dump burst longer than eight beats", $time);
		err_cnt++;
	end

	// ----------------------------------------
	// helpers
	task automatic abort_wait(input string what);
		hang_what = what;
		timed_out = 1'b1;
		forever @(posedge clk);                  // parks this process
	endtask

	initial
	begin
		wait (timed_out);
		$display("timeout: no %s within the allowed cycles", hang_what);
		$display("Some tests failed");
		$finish;
	end

	task automatic bus_cycle(input logic we, input corr_pkg::wb_reg_e addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		wb_req.cyc   = 1'b1;
		wb_req.stb   = 1'b1;
		wb_req.we    = we;
		wb_req.adr   = addr;
		wb_req.dat_w = wdata;
		@(posedge clk);
		#1;
		while (!wb_rsp.ack)
		begin
			if (n == 16)
				abort_wait("wishbone ack");
			n++;
			@(posedge clk);
			#1;
		end
		rdata  = wb_rsp.dat_r;                   // valid with ack
		wb_req = '0;                             // idle cycle follows
	endtask

	task automatic write_reg(input corr_pkg::wb_reg_e addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_cycle(1'b1, addr, data, unused);
	endtask

	task automatic read_reg(input corr_pkg::wb_reg_e addr, output logic [31:0] data);
		bus_cycle(1'b0, addr, 32'd0, data);
	endtask

	task automatic check_readback(input corr_pkg::wb_reg_e addr, input string name,
		input logic [31:0] mask);
		logic [31:0] rd;
		rng = xorshift32(rng);
		write_reg(addr, rng);
		read_reg(addr, rd);
		check_value(name, rng & mask, rd);
	endtask

	// three quiet cycles in a row drain a stray unload
	task automatic wait_dump_idle();
		int n;
		int quiet;
		n     = 0;
		quiet = 0;
		while (quiet < 3)
		begin
			if (n == 64)
				abort_wait("end of dump unload");
			n++;
			quiet = dump.valid ? 0 : quiet + 1;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic setup_channel(input logic [31:0] code_freq, input logic [31:0] phase,
		input int len, input int shift);
		sample_en = 1'b0;
		wait_dump_idle();
		write_reg(corr_pkg::PRN_POLY, 32'd0);   // all chips +1
		write_reg(corr_pkg::PRN_SEED, 32'd0);
		write_reg(corr_pkg::CODE_FREQ, code_freq);
		write_reg(corr_pkg::CARRIER_FREQ, 32'd0);
		write_reg(corr_pkg::CARRIER_PHASE, phase);
		write_reg(corr_pkg::DUMP_CFG, {14'd0, 2'(shift), 16'(len)});
		write_reg(corr_pkg::CTRL, 32'd1);        // run bit restarts the channel
	endtask

	task automatic collect_dump(input logic [15:0] exp_i, input logic [15:0] exp_q,
		output int start);
		int n;
		n = 0;
		while (!dump.valid)
		begin
			if (n == 1000)
				abort_wait("dump_o.valid");
			n++;
			@(posedge clk);
			#1;
		end
		start = cycle_cnt;
		for (int beat = 0; beat < 8; beat++)
		begin
			check_value("dump_o.valid", 32'd1, 32'(dump.valid));
			check_value("dump_o.idx", 32'(beat), 32'(dump.idx));
			check_value("dump_o.i_sum", 32'(exp_i), 32'(dump.i_sum));
			check_value("dump_o.q_sum", 32'(exp_q), 32'(dump.q_sum));
			@(posedge clk);
			#1;
		end
	endtask

	// code freq 2^30 gives eight samples per chip
	task automatic run_round(input logic [31:0] phase, input int len, input int shift);
		corr_pkg::raw_sample_t s;
		int                    i_val;
		int                    q_val;
		logic [15:0]           exp_i;
		logic [15:0]           exp_q;
		int                    t0;
		int                    t1;
		int                    t2;
		rng   = xorshift32(rng);
		s     = corr_pkg::raw_sample_t'(rng[7:0]);
		i_val = sm_value(s.i_sign, s.i_mag);
		q_val = sm_value(s.q_sign, s.q_mag);
		exp_i = expected_sum(rotated(i_val, q_val, phase[31:30], 1'b0), len, shift);
		exp_q = expected_sum(rotated(i_val, q_val, phase[31:30], 1'b1), len, shift);
		setup_channel(32'h4000_0000, phase, len, shift);
		raw_sample = s;
		sample_en  = 1'b1;                       // one sample per cycle
		collect_dump(exp_i, exp_q, t0);
		collect_dump(exp_i, exp_q, t1);
		collect_dump(exp_i, exp_q, t2);
		check_value("dump period", 32'(len * 8), 32'(t1 - t0));
		check_value("dump period", 32'(len * 8), 32'(t2 - t1));
		sample_en = 1'b0;
	endtask

	// ----------------------------------------
	// test sequence
	initial
	begin
		logic [31:0] rd;
		int          len;
		int          shift;
		int          n;
		rst_b      = 1'b0;
		wb_req     = '0;
		sample_en  = 1'b0;
		raw_sample = '0;
		framing_on = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst_b = 1'b1;

		open_test();
		check_value("wb_o.ack", 32'd0, 32'(wb_rsp.ack));
		check_value("dump_o.valid", 32'd0, 32'(dump.valid));
		read_reg(corr_pkg::STATUS, rd);
		check_value("status.overrun", 32'd0, {31'd0, rd[0]});
		close_test("reset state");

		open_test();
		check_readback(corr_pkg::CARRIER_FREQ, "carrier_freq", 32'hffff_ffff);
		check_readback(corr_pkg::CODE_FREQ, "code_freq", 32'hffff_ffff);
		check_readback(corr_pkg::PRN_POLY, "prn_poly", 32'hffff_ffff);
		check_readback(corr_pkg::PRN_SEED, "prn_seed", 32'hffff_ffff);
		check_readback(corr_pkg::DUMP_CFG, "dump_cfg", 32'h0003_ffff);  // len and shift only
		close_test("register access");

		open_test();
		for (int r = 0; r < 4; r++)
		begin
			rng   = xorshift32(rng);
			len   = 2 + int'(rng % 32'd14);      // keeps the unload clear of the next dump
			shift = int'(rng[17:16]);
			run_round(32'd0, len, shift);
		end
		close_test("zero-polynomial correlation");

		open_test();
		run_round(32'd0, 2, 0);                  // tightest gap between bursts
		run_round(32'd0, 15, 1);
		close_test("dump framing");

		open_test();
		write_reg(corr_pkg::CARRIER_PHASE, 32'h8000_0000);
		read_reg(corr_pkg::CARRIER_PHASE, rd);
		check_value("carrier_phase", 32'h8000_0000, rd);
		for (int r = 0; r < 2; r++)
		begin
			rng   = xorshift32(rng);
			len   = 2 + int'(rng % 32'd14);
			shift = int'(rng[17:16]);
			run_round(32'h8000_0000, len, shift);  // quadrant 2 negates both
		end
		close_test("carrier quadrant");

		open_test();
		framing_on = 1'b0;
		setup_channel(32'h8000_0000, 32'd0, 1, 0);  // a dump every 4 samples
		sample_en = 1'b1;
		rd        = '0;
		n         = 0;
		while (!rd[0] && n < 20)
		begin
			n++;
			read_reg(corr_pkg::STATUS, rd);
		end
		check_value("status.overrun", 32'd1, {31'd0, rd[0]});
		sample_en = 1'b0;
		wait_dump_idle();
		write_reg(corr_pkg::CTRL, 32'd1);        // restart clears overrun
		read_reg(corr_pkg::STATUS, rd);
		check_value("status.overrun", 32'd0, {31'd0, rd[0]});
		close_test("overrun");

		$display("summary: %0d tests ok, %0d tests failed, %0d errors", pass_cnt, fail_cnt,
			err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+src
+incdir+testbench
src/corr_pkg.sv
src/corr_regs.sv
src/carrier_mixer.sv
src/code_prn_gen.sv
src/corr_bank.sv
src/correlator_top.sv
testbench/tb_correlator.sv

//--- Makefile
# correlator simulation with verilator

SRCS := $(filter-out +incdir+%,$(shell cat list.f)) src/corr_settings.svh testbench/tb_model.svh

.PHONY: run clean

run: obj_dir/Vtb_correlator
	obj_dir/Vtb_correlator > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Some tests failed" sim.log; then echo "simulation reported failures"; exit 1; fi
	@grep -q "All tests passed" sim.log || (echo "simulation ended early"; exit 1)

obj_dir/Vtb_correlator: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module tb_correlator

clean:
	rm -rf obj_dir sim.log
